//--- rtl/join_pkg.sv
package join_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////
  localparam int WINDOW_DEPTH = 16;  // sliding window slots
  localparam int FIFO_DEPTH   = 8;   // result buffer entries
  localparam int FIFO_AW      = $clog2(FIFO_DEPTH);

  ////////////////////////////////////////////////////////////
  // tuple and result types
  ////////////////////////////////////////////////////////////
  typedef logic [7:0]  key_t;
  typedef logic [7:0]  val_t;
  typedef logic [3:0]  slot_t;
  typedef logic [15:0] count_t;  // results written so far

  typedef struct packed {
    key_t key;
    val_t val;
  } tuple_t;

  // one match, key first, slot number in the low byte
  typedef struct packed {
    key_t       key;
    val_t       stream_val;
    val_t       window_val;
    logic [7:0] slot;
  } result_t;

  typedef struct packed {
    logic [13:0] rsvd;   // reads as zero
    logic        busy;
    logic        over;
    count_t      count;
  } status_t;

  // state machines
  typedef enum logic {ENG_IDLE, ENG_SCAN} engine_state_t;
  typedef enum logic {WR_IDLE, WR_WRITE} writer_state_t;

endpackage

//--- rtl/wb_pkg.sv
package wb_pkg;

  ////////////////////////////////////////////////////////////
  // wishbone classic
  ////////////////////////////////////////////////////////////
  typedef logic [31:0] wb_adr_t;  // byte address
  typedef logic [31:0] wb_dat_t;

  // master to slave
  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_dat_t dat;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic    ack;
    wb_dat_t dat;
  } wb_rsp_t;

  ////////////////////////////////////////////////////////////
  // host register map, byte offsets
  ////////////////////////////////////////////////////////////
  localparam wb_adr_t REG_CTRL        = 32'h00;  // bit 0 clears count and window
  localparam wb_adr_t REG_RESULT_BASE = 32'h04;
  localparam wb_adr_t REG_RESULT_MAX  = 32'h08;
  localparam wb_adr_t REG_WINDOW      = 32'h0C;  // tuple into window store
  localparam wb_adr_t REG_STREAM      = 32'h10;  // tuple to probe
  localparam wb_adr_t REG_STATUS      = 32'h14;

endpackage

//--- rtl/host_slave.sv
`timescale 1ns/10ps

module host_slave import join_pkg::*, wb_pkg::*; (
  input  logic    ap_clk,
  input  logic    rst_n,
  input  wb_req_t host_req,
  output wb_rsp_t host_rsp,
  input  logic    engine_busy,
  input  logic    fifo_empty,
  input  logic    writer_busy,
  input  count_t  count,
  input  logic    over,
  output logic    window_wr,
  output logic    stream_wr,
  output tuple_t  tuple,
  output logic    clear,
  output wb_adr_t result_base,
  output count_t  result_max
);

  logic    ack_q;
  wb_dat_t rd_dat;
  wb_dat_t rd_mux;
  wb_adr_t offset;
  logic    req;        // new transfer not yet acked
  logic    tuple_acc;  // window or stream write
  logic    stall;
  status_t status;

  assign offset    = {24'h0, host_req.adr[7:0]};  // only the low byte decodes
  assign req       = host_req.cyc && host_req.stb && !ack_q;
  assign tuple_acc = host_req.we && ((offset == REG_WINDOW) || (offset == REG_STREAM));
  assign stall     = tuple_acc && engine_busy;  // hold the host while a scan runs

  assign status = '{rsvd: '0,
                    busy: engine_busy || writer_busy || !fifo_empty,
                    over: over,
                    count: count};

  assign host_rsp = '{ack: ack_q, dat: rd_dat};

  ////////////////////////////////////////////////////////////
  // register writes and strobes
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q       <= 1'b0;
      window_wr   <= 1'b0;
      stream_wr   <= 1'b0;
      clear       <= 1'b0;
      result_base <= '0;
      result_max  <= '0;
    end else begin
      ack_q     <= 1'b0;  // strobes last one cycle
      window_wr <= 1'b0;
      stream_wr <= 1'b0;
      clear     <= 1'b0;
      if (req && !stall) begin
        ack_q <= 1'b1;
        if (host_req.we) begin
          case (offset)
            REG_CTRL:        clear       <= host_req.dat[0];
            REG_RESULT_BASE: result_base <= host_req.dat;
            REG_RESULT_MAX:  result_max  <= host_req.dat[15:0];
            REG_WINDOW:      window_wr   <= 1'b1;
            REG_STREAM:      stream_wr   <= 1'b1;
            default: ;  // status is read only
          endcase
        end
      end
    end
  end

  // read data
  always_comb begin
    case (offset)
      REG_RESULT_BASE: rd_mux = result_base;
      REG_RESULT_MAX:  rd_mux = wb_dat_t'(result_max);
      REG_STATUS:      rd_mux = wb_dat_t'(status);
      default:         rd_mux = '0;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (req && tuple_acc) begin
      tuple <= tuple_t'(host_req.dat[15:0]);
    end
    if (req) begin
      rd_dat <= rd_mux;
    end
  end

  // ack only answers a strobe that the master still holds
  assert property (@(posedge ap_clk) disable iff (!rst_n)
    host_rsp.ack |-> (host_req.cyc && host_req.stb));

endmodule

//--- rtl/join_engine.sv
`timescale 1ns/10ps

module join_engine import join_pkg::*; (
  input  logic    ap_clk,
  input  logic    rst_n,
  input  logic    window_wr,
  input  logic    stream_wr,
  input  tuple_t  tuple,
  input  logic    clear,
  input  logic    fifo_full,
  output logic    push,
  output result_t result,
  output logic    engine_busy
);

  tuple_t                  win_mem [WINDOW_DEPTH];
  logic [WINDOW_DEPTH-1:0] slot_valid;
  slot_t                   wr_ptr;    // oldest slot is next to overwrite
  slot_t                   scan_idx;
  tuple_t                  probe;     // latched stream tuple
  tuple_t                  cur;
  engine_state_t           state;
  logic                    hit;
  logic                    last_slot;

  ////////////////////////////////////////////////////////////
  // window store
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ap_clk) begin
    if (window_wr) begin
      win_mem[wr_ptr] <= tuple;
    end
  end

  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_valid <= '0;
      wr_ptr     <= '0;
    end else if (clear) begin
      slot_valid <= '0;
      wr_ptr     <= '0;
    end else if (window_wr) begin
      slot_valid[wr_ptr] <= 1'b1;
      wr_ptr             <= wr_ptr + 1'b1;  // wraps at 16
    end
  end

  ////////////////////////////////////////////////////////////
  // probe scan at one slot per cycle
  ////////////////////////////////////////////////////////////
  assign cur         = win_mem[scan_idx];
  assign hit         = slot_valid[scan_idx] && (cur.key == probe.key);
  assign last_slot   = (scan_idx == slot_t'(WINDOW_DEPTH - 1));
  assign engine_busy = (state == ENG_SCAN);
  assign push        = engine_busy && hit && !fifo_full;

  assign result = '{key:        probe.key,
                    stream_val: probe.val,
                    window_val: cur.val,
                    slot:       {4'h0, scan_idx}};

  always_ff @(posedge ap_clk) begin
    if (stream_wr) begin
      probe <= tuple;
    end
  end

  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ENG_IDLE;
      scan_idx <= '0;
    end else if (clear) begin
      state <= ENG_IDLE;
    end else begin
      case (state)
        ENG_IDLE: begin
          if (stream_wr) begin
            state    <= ENG_SCAN;
            scan_idx <= '0;
          end
        end
        ENG_SCAN: begin
          if (!fifo_full) begin  // hold slot while the buffer is full
            if (last_slot) state <= ENG_IDLE;
            scan_idx <= scan_idx + 1'b1;
          end
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

  // software clears only between scans
  assert property (@(posedge ap_clk) disable iff (!rst_n)
    clear |-> !engine_busy);

  // host side stalls tuple writes for the whole scan
  assert property (@(posedge ap_clk) disable iff (!rst_n)
    engine_busy |-> !(window_wr || stream_wr));

endmodule

//--- rtl/result_fifo.sv
`timescale 1ns/10ps

module result_fifo import join_pkg::*; (
  input  logic    ap_clk,
  input  logic    rst_n,
  input  logic    push,
  input  result_t din,
  input  logic    pop,
  output result_t dout,
  output logic    full,
  output logic    empty
);

  result_t            mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   used;   // occupancy, one bit wider than the pointers

  assign full  = (used == (FIFO_AW + 1)'(FIFO_DEPTH));
  assign empty = (used == '0);
  assign dout  = mem[rd_ptr];  // head

  always_ff @(posedge ap_clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: ;  // both or neither
      endcase
    end
  end

  // producer and consumer must honour the flags
  assert property (@(posedge ap_clk) disable iff (!rst_n)
    full |-> !push);

  assert property (@(posedge ap_clk) disable iff (!rst_n)
    empty |-> !pop);

endmodule

//--- rtl/result_writer.sv
`timescale 1ns/10ps

module result_writer import join_pkg::*, wb_pkg::*; (
  input  logic    ap_clk,
  input  logic    rst_n,
  input  logic    clear,
  input  logic    empty,
  input  result_t head,
  output logic    pop,
  input  wb_adr_t result_base,
  input  count_t  result_max,
  output wb_req_t mem_req,
  input  wb_rsp_t mem_rsp,
  output count_t  count,
  output logic    over,
  output logic    writer_busy
);

  writer_state_t state;
  wb_adr_t       adr_q;
  wb_dat_t       dat_q;
  logic          active;     // write cycle on the bus
  logic          take;
  logic          under_max;

  assign active      = (state == WR_WRITE);
  assign under_max   = (count < result_max);
  assign take        = (state == WR_IDLE) && !empty && !clear;
  assign pop         = take;  // pop either writes or discards
  assign writer_busy = active;

  assign mem_req = '{cyc: active,
                     stb: active,
                     we:  active,
                     adr: adr_q,
                     dat: dat_q};

  ////////////////////////////////////////////////////////////
  // address and data for the next write
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ap_clk) begin
    if (take && under_max) begin
      adr_q <= result_base + (wb_adr_t'(count) << 2);  // one word per result
      dat_q <= wb_dat_t'(head);
    end
  end

  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= WR_IDLE;
      count <= '0;
      over  <= 1'b0;
    end else if (clear) begin
      state <= WR_IDLE;
      count <= '0;
      over  <= 1'b0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (take) begin
            if (under_max) state <= WR_WRITE;
            else           over  <= 1'b1;  // drop it once the limit is reached
          end
        end
        WR_WRITE: begin
          if (mem_rsp.ack) begin
            count <= count + 1'b1;
            state <= WR_IDLE;
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // the memory slave acks only a strobed cycle
  assert property (@(posedge ap_clk) disable iff (!rst_n)
    mem_rsp.ack |-> (mem_req.cyc && mem_req.stb));

endmodule

//--- rtl/join_top.sv
`timescale 1ns/10ps

module join_top import join_pkg::*, wb_pkg::*; (
  input  logic    ap_clk,
  input  logic    rst_n,
  input  wb_req_t host_req,
  output wb_rsp_t host_rsp,
  output wb_req_t mem_req,
  input  wb_rsp_t mem_rsp
);

  // host port to engine
  logic    window_wr;
  logic    stream_wr;
  tuple_t  tuple;
  logic    clear;
  logic    engine_busy;

  // engine to fifo to writer
  logic    push;
  result_t push_data;
  logic    fifo_full;
  logic    fifo_empty;
  logic    pop;
  result_t head;

  // writer config and status
  wb_adr_t result_base;
  count_t  result_max;
  count_t  count;
  logic    over;
  logic    writer_busy;

  host_slave u_host_slave (
    .ap_clk      (ap_clk),
    .rst_n       (rst_n),
    .host_req    (host_req),
    .host_rsp    (host_rsp),
    .engine_busy (engine_busy),
    .fifo_empty  (fifo_empty),
    .writer_busy (writer_busy),
    .count       (count),
    .over        (over),
    .window_wr   (window_wr),
    .stream_wr   (stream_wr),
    .tuple       (tuple),
    .clear       (clear),
    .result_base (result_base),
    .result_max  (result_max)
  );

  join_engine u_join_engine (
    .ap_clk      (ap_clk),
    .rst_n       (rst_n),
    .window_wr   (window_wr),
    .stream_wr   (stream_wr),
    .tuple       (tuple),
    .clear       (clear),
    .fifo_full   (fifo_full),
    .push        (push),
    .result      (push_data),
    .engine_busy (engine_busy)
  );

  result_fifo u_result_fifo (
    .ap_clk (ap_clk),
    .rst_n  (rst_n),
    .push   (push),
    .din    (push_data),
    .pop    (pop),
    .dout   (head),
    .full   (fifo_full),
    .empty  (fifo_empty)
  );

  result_writer u_result_writer (
    .ap_clk      (ap_clk),
    .rst_n       (rst_n),
    .clear       (clear),
    .empty       (fifo_empty),
    .head        (head),
    .pop         (pop),
    .result_base (result_base),
    .result_max  (result_max),
    .mem_req     (mem_req),
    .mem_rsp     (mem_rsp),
    .count       (count),
    .over        (over),
    .writer_busy (writer_busy)
  );

endmodule

//--- testbench/tb_join_model.svh
`ifndef TB_JOIN_MODEL_SVH
`define TB_JOIN_MODEL_SVH

////////////////////////////////////////////////////////////
// window mirror and expected result list
////////////////////////////////////////////////////////////
tuple_t  m_slot [WINDOW_DEPTH];
logic    m_valid [WINDOW_DEPTH];
int      m_ptr;
result_t exp_q [$];  // every match since the last clear, in order

task automatic model_clear();
  foreach (m_valid[i]) m_valid[i] = 1'b0;
  m_ptr = 0;
  exp_q.delete();
endtask

// oldest slot is overwritten first
task automatic model_window(input tuple_t t);
  m_slot[m_ptr]  = t;
  m_valid[m_ptr] = 1'b1;
  m_ptr          = (m_ptr + 1) % WINDOW_DEPTH;
endtask

// matches in ascending slot order
task automatic model_stream(input tuple_t t);
  result_t r;
  for (int i = 0; i < WINDOW_DEPTH; i++) begin
    if (m_valid[i] && (m_slot[i].key == t.key)) begin
      r.key        = t.key;
      r.stream_val = t.val;
      r.window_val = m_slot[i].val;
      r.slot       = 8'(i);
      exp_q.push_back(r);
    end
  end
endtask

`endif

//--- testbench/tb_join_top.sv
`timescale 1ns/10ps

module tb_join_top import join_pkg::*, wb_pkg::*;;

  logic    ap_clk;
  logic    rst_n;
  wb_req_t host_req;
  wb_rsp_t host_rsp;
  wb_req_t mem_req;
  wb_rsp_t mem_rsp;

  int      seed     = 43305;
  int      ack_seed = 43305;  // separate stream for the memory delays
  int      ack_wait = 0;
  logic    mem_ack  = 1'b0;
  wb_dat_t mem [wb_adr_t];    // written words by byte address

  `include "tb_join_model.svh"

  join_top u_dut (
    .ap_clk   (ap_clk),
    .rst_n    (rst_n),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp)
  );

  initial begin
    ap_clk = 1'b0;
    forever #20 ap_clk = ~ap_clk;
  end

  ////////////////////////////////////////////////////////////
  // memory slave with a random 0 to 3 cycle ack delay
  ////////////////////////////////////////////////////////////
  assign mem_rsp = '{ack: mem_ack, dat: '0};

  always @(posedge ap_clk) begin
    mem_ack <= 1'b0;
    if (mem_req.cyc && mem_req.stb && mem_req.we && !mem_ack) begin
      if (ack_wait == 0) begin
        mem_ack <= 1'b1;
        mem[mem_req.adr] = mem_req.dat;
        ack_wait <= $random(ack_seed) & 3;
      end else begin
        ack_wait <= ack_wait - 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_result(input string name, input result_t got, input result_t exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: %s got %08h expected %08h", name, got, exp));
    end
  endtask

  task automatic check_status(input string name, input status_t got, input status_t exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: %s got %08h expected %08h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // host bus
  ////////////////////////////////////////////////////////////
  task automatic host_access(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                             output wb_dat_t rdat);
    int n;
    n = 0;
    @(posedge ap_clk);
    host_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    do begin
      @(posedge ap_clk);
      n++;
      if (n > 2000) fail_run($sformatf("host access to %02h never acked", adr));
    end while (!host_rsp.ack);
    rdat = host_rsp.dat;
    host_req <= '0;
  endtask

  task automatic host_write(input wb_adr_t adr, input wb_dat_t dat);
    wb_dat_t unused;
    host_access(1'b1, adr, dat, unused);
  endtask

  task automatic read_status(output status_t st);
    wb_dat_t d;
    host_access(1'b0, REG_STATUS, '0, d);
    st = status_t'(d);
  endtask

  // poll until engine, fifo and writer are all drained
  task automatic wait_idle(output status_t st);
    int n;
    n = 0;
    read_status(st);
    while (st.busy) begin
      n++;
      if (n > 500) fail_run("join still busy after 500 status reads");
      read_status(st);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // scenario steps
  ////////////////////////////////////////////////////////////
  function automatic tuple_t random_tuple(input key_t mask);
    tuple_t t;
    t.key = key_t'($random(seed)) & mask;  // small key range, frequent matches
    t.val = val_t'($random(seed));
    return t;
  endfunction

  task automatic add_window(input key_t mask);
    tuple_t t;
    t = random_tuple(mask);
    host_write(REG_WINDOW, wb_dat_t'(t));
    model_window(t);
  endtask

  task automatic add_stream(input key_t mask);
    tuple_t t;
    t = random_tuple(mask);
    host_write(REG_STREAM, wb_dat_t'(t));
    model_stream(t);
  endtask

  // clear, configure, and expect a zero status
  task automatic start_scenario(input wb_adr_t base, input count_t max);
    status_t st;
    host_write(REG_CTRL, 32'h1);
    host_write(REG_RESULT_BASE, base);
    host_write(REG_RESULT_MAX, wb_dat_t'(max));
    mem.delete();
    model_clear();
    read_status(st);
    check_status("status", st, '0);
  endtask

  task automatic finish_scenario(input wb_adr_t base, input count_t max);
    status_t st;
    status_t exp;
    int      nw;
    wb_adr_t adr;
    wait_idle(st);
    nw        = (exp_q.size() < int'(max)) ? exp_q.size() : int'(max);
    exp       = '0;
    exp.count = count_t'(nw);
    exp.over  = (exp_q.size() > int'(max));
    check_status("status", st, exp);
    if (mem.num() != nw) begin
      fail_run($sformatf("** Error: mem_writes got %0h expected %0h", mem.num(), nw));
    end
    for (int i = 0; i < nw; i++) begin
      adr = base + wb_adr_t'(4 * i);
      if (!mem.exists(adr)) fail_run($sformatf("no memory write at address %08h", adr));
      check_result($sformatf("mem[%08h]", adr), result_t'(mem[adr]), exp_q[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    status_t st;
    rst_n    = 1'b0;
    host_req = '0;
    repeat (10) @(posedge ap_clk);
    rst_n <= 1'b1;

    read_status(st);  // idle after reset
    check_status("status", st, '0);
    if (mem.num() != 0) fail_run("memory written right after reset");

    // wide limit, window wraps past sixteen entries
    start_scenario(32'h1000, 16'd255);
    repeat (20) add_window(8'h07);
    repeat (30) begin
      if ($random(seed) & 1) add_window(8'h07);
      else add_stream(8'h07);
    end
    finish_scenario(32'h1000, 16'd255);

    // small limit, excess results dropped
    start_scenario(32'h2000, 16'd5);
    repeat (12) add_window(8'h03);
    repeat (8) add_stream(8'h03);
    finish_scenario(32'h2000, 16'd5);

    // dense matches fill the fifo
    start_scenario(32'h3000, 16'd255);
    repeat (16) add_window(8'h01);
    repeat (8) add_stream(8'h01);
    finish_scenario(32'h3000, 16'd255);

    // clear left the window empty
    start_scenario(32'h4000, 16'd255);
    repeat (4) add_stream(8'h07);
    finish_scenario(32'h4000, 16'd255);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- tb.f
+incdir+testbench
rtl/join_pkg.sv
rtl/wb_pkg.sv
rtl/host_slave.sv
rtl/join_engine.sv
rtl/result_fifo.sv
rtl/result_writer.sv
rtl/join_top.sv
testbench/tb_join_top.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module tb_join_top -f tb.f

run: compile
	./obj_dir/Vtb_join_top | grep "Simulation PASSED"

clean:
	rm -rf obj_dir
